/* include/trap_trace_settings.svh */
`ifndef TRAP_TRACE_SETTINGS_SVH
`define TRAP_TRACE_SETTINGS_SVH

// Datapath widths of the trace port
`define TRAP_TRACE_PC_W        32
`define TRAP_TRACE_ORDER_W     16
`define TRAP_TRACE_CAUSE_W     6
`define TRAP_TRACE_IRQ_ID_W    5
`define TRAP_TRACE_DBG_CAUSE_W 3

// Debug entry causes as reported on rvfi_dbg where zero means no debug entry
`define TRAP_TRACE_DBG_HALTREQ 3'h3
`define TRAP_TRACE_DBG_STEP    3'h4

`endif

/* src/trap_trace_pkg.sv */
`default_nettype none

`include "trap_trace_settings.svh"

package trap_trace_pkg;

  //////////////////////////////////////////////////////////////////////
  // Trace annotation types
  //////////////////////////////////////////////////////////////////////

  // Debug entry cause that stays zero when the instruction follows no debug entry
  typedef logic [`TRAP_TRACE_DBG_CAUSE_W-1:0] dbg_cause_t;

  // Trap information of the retiring instruction itself
  // The exception cause is reported on its own port next to this struct
  typedef struct packed {
    logic       exception;
    logic       debug;
    dbg_cause_t debug_cause;
  } trap_t;

  // Marks the first instruction retired after a trap was taken
  // Interrupt tells an asynchronous entry apart from a synchronous one
  typedef struct packed {
    logic                          intr;
    logic                          interrupt;
    logic [`TRAP_TRACE_CAUSE_W-1:0] cause;
  } intr_t;

  //////////////////////////////////////////////////////////////////////
  // Pipeline and controller types
  //////////////////////////////////////////////////////////////////////

  // Contents of one trace pipeline stage
  typedef struct packed {
    logic                          valid;
    logic [`TRAP_TRACE_PC_W-1:0]    pc;
    logic                          exc;
    logic [`TRAP_TRACE_CAUSE_W-1:0] exc_cause;
    logic                          dret;
  } stage_item_t;

  // Controller mode is either normal execution or halted in debug mode
  typedef enum logic {
    CTRL_RUN   = 1'b0,
    CTRL_DEBUG = 1'b1
  } ctrl_state_e;

endpackage

`default_nettype wire

/* src/trace_stage_if.sv */
`default_nettype none

// Carries the WB stage and the retire decisions between the pipeline,
// the controller and the retire formatter
interface trace_stage_if;

  trap_trace_pkg::stage_item_t wb_item;
  logic                        retire;
  logic                        step_trap;
  logic                        flush_all;
  logic                        flush_young;

  // The pipeline owns the WB contents and obeys both flushes
  modport pipe (output wb_item, input flush_all, input flush_young);

  // The controller looks at WB and decides what happens to it
  modport ctrl (input wb_item, output retire, output step_trap, output flush_all,
                output flush_young);

  // The retire formatter only observes
  modport rvfi (input wb_item, input retire, input step_trap, input flush_all,
                input flush_young);

endinterface

`default_nettype wire

/* src/trace_ctrl_fsm.sv */
`default_nettype none

`include "trap_trace_settings.svh"

module trace_ctrl_fsm (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            irq_i,
  input  logic [`TRAP_TRACE_IRQ_ID_W-1:0] irq_id_i,
  input  logic                            dbg_req_i,
  input  logic                            step_i,
  trace_stage_if.ctrl                     stage,
  output logic                            irq_ack_o,
  output logic                            dbg_ack_o,
  output logic                            debug_mode_o,
  output trap_trace_pkg::intr_t           pend_intr_o,
  output trap_trace_pkg::dbg_cause_t      pend_dbg_o
);

  trap_trace_pkg::ctrl_state_e state_q;
  trap_trace_pkg::ctrl_state_e state_d;
  trap_trace_pkg::intr_t       pend_intr_q;
  trap_trace_pkg::intr_t       pend_intr_d;
  trap_trace_pkg::dbg_cause_t  pend_dbg_q;
  trap_trace_pkg::dbg_cause_t  pend_dbg_d;

  logic in_run;
  logic exc_ret;
  logic step_ret;
  logic trap_win;
  logic dbg_take;
  logic irq_take;
  logic retire;

  //////////////////////////////////////////////////////////////////////
  // Event arbitration
  //////////////////////////////////////////////////////////////////////

  assign in_run = (state_q == trap_trace_pkg::CTRL_RUN);

  // An exception or a single step retiring from WB has the highest priority
  // Stepping only applies while running and debug mode executes freely
  assign exc_ret  = stage.wb_item.valid & stage.wb_item.exc;
  assign step_ret = stage.wb_item.valid & step_i & in_run;
  assign trap_win = exc_ret | step_ret;

  // Halt requests beat interrupts, and both wait while a trap retires
  // A loser simply tries again next cycle as long as its level is held
  assign dbg_take = dbg_req_i & in_run & ~trap_win;
  assign irq_take = irq_i & in_run & ~trap_win & ~dbg_req_i;

  // Taking an interrupt or a halt kills everything in flight including WB
  assign retire = stage.wb_item.valid & ~(dbg_take | irq_take);

  assign stage.retire      = retire;
  assign stage.step_trap   = step_ret;
  assign stage.flush_all   = dbg_take | irq_take;
  assign stage.flush_young = trap_win;

  assign irq_ack_o    = irq_take;
  assign dbg_ack_o    = dbg_take;
  assign debug_mode_o = ~in_run;
  assign pend_intr_o  = pend_intr_q;
  assign pend_dbg_o   = pend_dbg_q;

  //////////////////////////////////////////////////////////////////////
  // Next state and pending annotations
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    pend_intr_d = pend_intr_q;
    pend_dbg_d  = pend_dbg_q;

    // A retirement carries the annotations out, so they are used up here
    if (retire) begin
      pend_intr_d = '0;
      pend_dbg_d  = '0;
    end

    // The handler's first instruction reports the exception cause
    if (exc_ret) begin
      pend_intr_d.intr      = 1'b1;
      pend_intr_d.interrupt = 1'b0;
      pend_intr_d.cause     = stage.wb_item.exc_cause;
    end

    if (irq_take) begin
      pend_intr_d.intr      = 1'b1;
      pend_intr_d.interrupt = 1'b1;
      pend_intr_d.cause     = `TRAP_TRACE_CAUSE_W'(irq_id_i);
    end

    // Step and halt both drop the core into debug mode
    if (step_ret) begin
      pend_dbg_d = `TRAP_TRACE_DBG_STEP;
      state_d    = trap_trace_pkg::CTRL_DEBUG;
    end else if (dbg_take) begin
      pend_dbg_d = `TRAP_TRACE_DBG_HALTREQ;
      state_d    = trap_trace_pkg::CTRL_DEBUG;
    end

    // Leaving debug mode happens when dret itself retires
    if (!in_run && retire && stage.wb_item.dret) begin
      state_d = trap_trace_pkg::CTRL_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= trap_trace_pkg::CTRL_RUN;
      pend_intr_q <= '0;
      pend_dbg_q  <= '0;
    end else begin
      state_q     <= state_d;
      pend_intr_q <= pend_intr_d;
      pend_dbg_q  <= pend_dbg_d;
    end
  end

endmodule

`default_nettype wire

/* src/trace_pipe.sv */
`default_nettype none

`include "trap_trace_settings.svh"

module trace_pipe (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           instr_valid_i,
  input  logic [`TRAP_TRACE_PC_W-1:0]    instr_pc_i,
  input  logic                           instr_exc_i,
  input  logic [`TRAP_TRACE_CAUSE_W-1:0] instr_exc_cause_i,
  input  logic                           instr_dret_i,
  trace_stage_if.pipe                    stage
);

  trap_trace_pkg::stage_item_t in_item;
  trap_trace_pkg::stage_item_t if_q;
  trap_trace_pkg::stage_item_t id_q;
  trap_trace_pkg::stage_item_t wb_q;

  logic if_valid_q;
  logic id_valid_q;
  logic wb_valid_q;
  logic flush;

  // Both flushes empty the whole pipe at the edge
  // With flush_young the WB instruction still retires while flush_all kills it
  assign flush = stage.flush_all | stage.flush_young;

  always_comb begin
    in_item.valid     = instr_valid_i;
    in_item.pc        = instr_pc_i;
    in_item.exc       = instr_exc_i;
    in_item.exc_cause = instr_exc_cause_i;
    in_item.dret      = instr_dret_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Stage valids
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      if_valid_q <= 1'b0;
      id_valid_q <= 1'b0;
      wb_valid_q <= 1'b0;
    end else if (flush) begin
      if_valid_q <= 1'b0;
      id_valid_q <= 1'b0;
      wb_valid_q <= 1'b0;
    end else begin
      if_valid_q <= instr_valid_i;
      id_valid_q <= if_valid_q;
      wb_valid_q <= id_valid_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage payload
  //////////////////////////////////////////////////////////////////////

  // No stalls, so the payload shifts every cycle and the valids qualify it
  always_ff @(posedge clk_i) begin
    if_q <= in_item;
    id_q <= if_q;
    wb_q <= id_q;
  end

  always_comb begin
    stage.wb_item       = wb_q;
    stage.wb_item.valid = wb_valid_q;
  end

endmodule

`default_nettype wire

/* src/retire_counter.sv */
`default_nettype none

module retire_counter #(
  parameter int unsigned WIDTH = 16
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             inc_i,
  output logic [WIDTH-1:0] count_o
);

  logic [WIDTH-1:0] count_q;

  // Counts retirements, wrapping back to zero after the all ones value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (inc_i) begin
      count_q <= count_q + WIDTH'(1);
    end
  end

  // The value before the increment numbers the instruction retiring now
  assign count_o = count_q;

endmodule

`default_nettype wire

/* src/trace_retire.sv */
`default_nettype none

`include "trap_trace_settings.svh"

module trace_retire (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  trace_stage_if.rvfi                     stage,
  input  trap_trace_pkg::intr_t           pend_intr_i,
  input  trap_trace_pkg::dbg_cause_t      pend_dbg_i,
  input  logic                            debug_mode_i,
  input  logic [`TRAP_TRACE_ORDER_W-1:0]  order_i,
  output logic                            rvfi_valid_o,
  output logic [`TRAP_TRACE_PC_W-1:0]     rvfi_pc_o,
  output logic [`TRAP_TRACE_ORDER_W-1:0]  rvfi_order_o,
  output trap_trace_pkg::trap_t           rvfi_trap_o,
  output logic [`TRAP_TRACE_CAUSE_W-1:0]  rvfi_exc_cause_o,
  output trap_trace_pkg::intr_t           rvfi_intr_o,
  output trap_trace_pkg::dbg_cause_t      rvfi_dbg_o,
  output logic                            rvfi_dbg_mode_o
);

  trap_trace_pkg::trap_t          trap_d;
  logic [`TRAP_TRACE_CAUSE_W-1:0] exc_cause_d;

  // A step trap on an excepting instruction sets both trap bits
  // and still names single step as the debug cause
  always_comb begin
    trap_d.exception   = stage.wb_item.exc;
    trap_d.debug       = stage.step_trap;
    trap_d.debug_cause = stage.step_trap ? `TRAP_TRACE_DBG_STEP : '0;
    exc_cause_d        = stage.wb_item.exc ? stage.wb_item.exc_cause : '0;
  end

  // Outputs hold their last retirement between valid cycles
  // A flushed WB instruction never reaches this point since retire is low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o     <= 1'b0;
      rvfi_pc_o        <= '0;
      rvfi_order_o     <= '0;
      rvfi_trap_o      <= '0;
      rvfi_exc_cause_o <= '0;
      rvfi_intr_o      <= '0;
      rvfi_dbg_o       <= '0;
      rvfi_dbg_mode_o  <= 1'b0;
    end else begin
      rvfi_valid_o <= stage.retire;
      if (stage.retire) begin
        rvfi_pc_o        <= stage.wb_item.pc;
        rvfi_order_o     <= order_i;
        rvfi_trap_o      <= trap_d;
        rvfi_exc_cause_o <= exc_cause_d;
        // Annotations describe what happened before this instruction
        rvfi_intr_o      <= pend_intr_i;
        rvfi_dbg_o       <= pend_dbg_i;
        rvfi_dbg_mode_o  <= debug_mode_i;
      end
    end
  end

endmodule

`default_nettype wire

/* src/trap_trace_top.sv */
`default_nettype none

`include "trap_trace_settings.svh"

module trap_trace_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            instr_valid_i,
  input  logic [`TRAP_TRACE_PC_W-1:0]     instr_pc_i,
  input  logic                            instr_exc_i,
  input  logic [`TRAP_TRACE_CAUSE_W-1:0]  instr_exc_cause_i,
  input  logic                            instr_dret_i,
  input  logic                            irq_i,
  input  logic [`TRAP_TRACE_IRQ_ID_W-1:0] irq_id_i,
  input  logic                            dbg_req_i,
  input  logic                            step_i,
  output logic                            irq_ack_o,
  output logic                            dbg_ack_o,
  output logic                            rvfi_valid_o,
  output logic [`TRAP_TRACE_PC_W-1:0]     rvfi_pc_o,
  output logic [`TRAP_TRACE_ORDER_W-1:0]  rvfi_order_o,
  output trap_trace_pkg::trap_t           rvfi_trap_o,
  output logic [`TRAP_TRACE_CAUSE_W-1:0]  rvfi_exc_cause_o,
  output trap_trace_pkg::intr_t           rvfi_intr_o,
  output trap_trace_pkg::dbg_cause_t      rvfi_dbg_o,
  output logic                            rvfi_dbg_mode_o,
  output logic                            debug_mode_o
);

  trap_trace_pkg::intr_t          pend_intr;
  trap_trace_pkg::dbg_cause_t     pend_dbg;
  logic [`TRAP_TRACE_ORDER_W-1:0] order;

  trace_stage_if stage_if ();

  //////////////////////////////////////////////////////////////////////
  // Pipeline, controller and retire port
  //////////////////////////////////////////////////////////////////////

  trace_pipe u_pipe (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_pc_i        (instr_pc_i),
    .instr_exc_i       (instr_exc_i),
    .instr_exc_cause_i (instr_exc_cause_i),
    .instr_dret_i      (instr_dret_i),
    .stage             (stage_if.pipe)
  );

  trace_ctrl_fsm u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_i        (irq_i),
    .irq_id_i     (irq_id_i),
    .dbg_req_i    (dbg_req_i),
    .step_i       (step_i),
    .stage        (stage_if.ctrl),
    .irq_ack_o    (irq_ack_o),
    .dbg_ack_o    (dbg_ack_o),
    .debug_mode_o (debug_mode_o),
    .pend_intr_o  (pend_intr),
    .pend_dbg_o   (pend_dbg)
  );

  // Every retirement takes the next order number
  retire_counter #(
    .WIDTH (`TRAP_TRACE_ORDER_W)
  ) u_order (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .inc_i   (stage_if.retire),
    .count_o (order)
  );

  trace_retire u_retire (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .stage            (stage_if.rvfi),
    .pend_intr_i      (pend_intr),
    .pend_dbg_i       (pend_dbg),
    .debug_mode_i     (debug_mode_o),
    .order_i          (order),
    .rvfi_valid_o     (rvfi_valid_o),
    .rvfi_pc_o        (rvfi_pc_o),
    .rvfi_order_o     (rvfi_order_o),
    .rvfi_trap_o      (rvfi_trap_o),
    .rvfi_exc_cause_o (rvfi_exc_cause_o),
    .rvfi_intr_o      (rvfi_intr_o),
    .rvfi_dbg_o       (rvfi_dbg_o),
    .rvfi_dbg_mode_o  (rvfi_dbg_mode_o)
  );

endmodule

`default_nettype wire

/* test/trap_trace_props.sv */
`default_nettype none

`include "trap_trace_settings.svh"

module trap_trace_props (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           irq_ack_o,
  input logic                           dbg_ack_o,
  input logic                           debug_mode_o,
  input logic                           rvfi_valid_o,
  input trap_trace_pkg::trap_t          rvfi_trap_o,
  input logic [`TRAP_TRACE_CAUSE_W-1:0] rvfi_exc_cause_o,
  input trap_trace_pkg::intr_t          rvfi_intr_o,
  input trap_trace_pkg::dbg_cause_t     rvfi_dbg_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic                           irq_wait_q;
  logic                           exc_wait_q;
  logic                           step_wait_q;
  logic [`TRAP_TRACE_CAUSE_W-1:0] exc_cause_q;
  int                             fail_cnt = 0;

  //////////////////////////////////////////////////////////////////////
  // Trackers for the next retirement after a trap
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_wait_q  <= 1'b0;
      exc_wait_q  <= 1'b0;
      step_wait_q <= 1'b0;
      exc_cause_q <= '0;
    end else begin
      if (irq_ack_o) begin
        irq_wait_q <= 1'b1;
      end else if (rvfi_valid_o) begin
        irq_wait_q <= 1'b0;
      end
      // An interrupt taken before the handler retires replaces the exception annotation
      if (irq_ack_o) begin
        exc_wait_q <= 1'b0;
      end else if (rvfi_valid_o && rvfi_trap_o.exception) begin
        exc_wait_q  <= 1'b1;
        exc_cause_q <= rvfi_exc_cause_o;
      end else if (rvfi_valid_o) begin
        exc_wait_q <= 1'b0;
      end
      if (rvfi_valid_o) begin
        step_wait_q <= rvfi_trap_o.debug && (rvfi_trap_o.debug_cause == `TRAP_TRACE_DBG_STEP);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////////////////////////

  irq_intr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_wait_q && rvfi_valid_o |-> rvfi_intr_o.intr && rvfi_intr_o.interrupt)
    else begin
      $error("Retirement after an interrupt acknowledge has no interrupt annotation");
      fail_cnt++;
    end

  exc_intr_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exc_wait_q && rvfi_valid_o |->
      rvfi_intr_o.intr && !rvfi_intr_o.interrupt && (rvfi_intr_o.cause == exc_cause_q))
    else begin
      $error("Retirement after an exception has a wrong intr annotation");
      fail_cnt++;
    end

  step_dbg_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    step_wait_q && rvfi_valid_o |-> rvfi_dbg_o == `TRAP_TRACE_DBG_STEP)
    else begin
      $error("Retirement after a step trap does not report the step cause");
      fail_cnt++;
    end

  // Debug mode takes neither interrupts nor new halt requests
  ack_in_debug_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_ack_o || dbg_ack_o) |-> !debug_mode_o)
    else begin
      $error("Acknowledge raised while in debug mode");
      fail_cnt++;
    end

endmodule

bind trap_trace_top trap_trace_props u_props (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .irq_ack_o        (irq_ack_o),
  .dbg_ack_o        (dbg_ack_o),
  .debug_mode_o     (debug_mode_o),
  .rvfi_valid_o     (rvfi_valid_o),
  .rvfi_trap_o      (rvfi_trap_o),
  .rvfi_exc_cause_o (rvfi_exc_cause_o),
  .rvfi_intr_o      (rvfi_intr_o),
  .rvfi_dbg_o       (rvfi_dbg_o)
);

`default_nettype wire

/* test/trap_trace_tb.sv */
`default_nettype none

`include "trap_trace_settings.svh"

module trap_trace_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES   = 10;
  localparam int STIM_CYCLES    = 2000;
  localparam int STEP_FIRST     = 700;
  localparam int STEP_LAST      = 1100;
  localparam int TIMEOUT_CYCLES = STIM_CYCLES + 50;

  // Expected state of the trace pipeline plus the rvfi registers
  typedef struct packed {
    trap_trace_pkg::stage_item_t    if_s;
    trap_trace_pkg::stage_item_t    id_s;
    trap_trace_pkg::stage_item_t    wb_s;
    logic                           debug;
    trap_trace_pkg::intr_t          pend_intr;
    trap_trace_pkg::dbg_cause_t     pend_dbg;
    logic [`TRAP_TRACE_ORDER_W-1:0] order;
    logic                           rv_valid;
    logic [`TRAP_TRACE_PC_W-1:0]    rv_pc;
    logic [`TRAP_TRACE_ORDER_W-1:0] rv_order;
    trap_trace_pkg::trap_t          rv_trap;
    logic [`TRAP_TRACE_CAUSE_W-1:0] rv_cause;
    trap_trace_pkg::intr_t          rv_intr;
    trap_trace_pkg::dbg_cause_t     rv_dbg;
    logic                           rv_dbg_mode;
  } model_t;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            instr_valid_i;
  logic [`TRAP_TRACE_PC_W-1:0]     instr_pc_i;
  logic                            instr_exc_i;
  logic [`TRAP_TRACE_CAUSE_W-1:0]  instr_exc_cause_i;
  logic                            instr_dret_i;
  logic                            irq_i;
  logic [`TRAP_TRACE_IRQ_ID_W-1:0] irq_id_i;
  logic                            dbg_req_i;
  logic                            step_i;
  logic                            irq_ack_o;
  logic                            dbg_ack_o;
  logic                            rvfi_valid_o;
  logic [`TRAP_TRACE_PC_W-1:0]     rvfi_pc_o;
  logic [`TRAP_TRACE_ORDER_W-1:0]  rvfi_order_o;
  trap_trace_pkg::trap_t           rvfi_trap_o;
  logic [`TRAP_TRACE_CAUSE_W-1:0]  rvfi_exc_cause_o;
  trap_trace_pkg::intr_t           rvfi_intr_o;
  trap_trace_pkg::dbg_cause_t      rvfi_dbg_o;
  logic                            rvfi_dbg_mode_o;
  logic                            debug_mode_o;

  model_t                      mdl;
  model_t                      nxt;
  trap_trace_pkg::stage_item_t fetch;
  logic                        exp_irq_ack;
  logic                        exp_dbg_ack;
  logic                        irq_ack_seen = 1'b0;
  logic                        dbg_ack_seen = 1'b0;
  logic [`TRAP_TRACE_PC_W-1:0] pc_next;
  int seed = 48;
  int cycle_cnt = 0;
  int check_cnt = 0;
  int err_cnt = 0;
  int other_cnt = 0;
  int n_irq_ack = 0;
  int n_dbg_ack = 0;
  int n_exc = 0;
  int n_step = 0;
  int n_step_exc = 0;

  trap_trace_top u_trap_trace_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Steps the trace rules over one clock edge and also returns the acks of the cycle before it
  function automatic model_t ref_next(input model_t s, input trap_trace_pkg::stage_item_t fi,
                                      input logic irq,
                                      input logic [`TRAP_TRACE_IRQ_ID_W-1:0] irq_id,
                                      input logic dbg_req, input logic step,
                                      output logic irq_ack, output logic dbg_ack);
    model_t n;
    logic   exc_ret;
    logic   step_ret;
    logic   take_dbg;
    logic   take_irq;
    logic   ret;
    n        = s;
    exc_ret  = s.wb_s.valid && s.wb_s.exc;
    step_ret = s.wb_s.valid && step && !s.debug;
    // Retiring traps win, then halt requests, then interrupts
    take_dbg = dbg_req && !s.debug && !(exc_ret || step_ret);
    take_irq = irq && !s.debug && !(exc_ret || step_ret) && !dbg_req;
    ret      = s.wb_s.valid && !take_dbg && !take_irq;
    irq_ack  = take_irq;
    dbg_ack  = take_dbg;
    n.rv_valid = ret;
    if (ret) begin
      n.rv_pc                = s.wb_s.pc;
      n.rv_order             = s.order;
      n.rv_trap.exception    = s.wb_s.exc;
      n.rv_trap.debug        = step_ret;
      n.rv_trap.debug_cause  = step_ret ? `TRAP_TRACE_DBG_STEP : 3'h0;
      n.rv_cause             = s.wb_s.exc ? s.wb_s.exc_cause : '0;
      n.rv_intr              = s.pend_intr;
      n.rv_dbg               = s.pend_dbg;
      n.rv_dbg_mode          = s.debug;
      n.order                = s.order + `TRAP_TRACE_ORDER_W'(1);
      n.pend_intr            = '0;
      n.pend_dbg             = '0;
    end
    if (exc_ret) begin
      n.pend_intr = {1'b1, 1'b0, s.wb_s.exc_cause};
    end
    if (take_irq) begin
      n.pend_intr = {1'b1, 1'b1, `TRAP_TRACE_CAUSE_W'(irq_id)};
    end
    if (step_ret || take_dbg) begin
      n.pend_dbg = step_ret ? `TRAP_TRACE_DBG_STEP : `TRAP_TRACE_DBG_HALTREQ;
      n.debug    = 1'b1;
    end
    if (s.debug && ret && s.wb_s.dret) begin
      n.debug = 1'b0;
    end
    // Any trap or ack empties the pipe including the input of this edge
    if (exc_ret || step_ret || take_dbg || take_irq) begin
      n.if_s = '0;
      n.id_s = '0;
      n.wb_s = '0;
    end else begin
      n.if_s = fi;
      n.id_s = s.if_s;
      n.wb_s = s.id_s;
    end
    return n;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Every DUT output has settled by the falling edge where the comparison runs
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      mdl = '0;
    end else begin
      fetch = {instr_valid_i, instr_pc_i, instr_exc_i, instr_exc_cause_i, instr_dret_i};
      nxt = ref_next(mdl, fetch, irq_i, irq_id_i, dbg_req_i, step_i, exp_irq_ack, exp_dbg_ack);
      check_field("irq_ack_o", 32'(irq_ack_o), 32'(exp_irq_ack));
      check_field("dbg_ack_o", 32'(dbg_ack_o), 32'(exp_dbg_ack));
      check_field("debug_mode_o", 32'(debug_mode_o), 32'(mdl.debug));
      check_field("rvfi_valid_o", 32'(rvfi_valid_o), 32'(mdl.rv_valid));
      check_field("rvfi_pc_o", rvfi_pc_o, mdl.rv_pc);
      check_field("rvfi_order_o", 32'(rvfi_order_o), 32'(mdl.rv_order));
      check_field("rvfi_trap_o", 32'(rvfi_trap_o), 32'(mdl.rv_trap));
      check_field("rvfi_exc_cause_o", 32'(rvfi_exc_cause_o), 32'(mdl.rv_cause));
      check_field("rvfi_intr_o", 32'(rvfi_intr_o), 32'(mdl.rv_intr));
      check_field("rvfi_dbg_o", 32'(rvfi_dbg_o), 32'(mdl.rv_dbg));
      check_field("rvfi_dbg_mode_o", 32'(rvfi_dbg_mode_o), 32'(mdl.rv_dbg_mode));
      if (exp_irq_ack) n_irq_ack++;
      if (exp_dbg_ack) n_dbg_ack++;
      if (nxt.rv_valid && nxt.rv_trap.exception) n_exc++;
      if (nxt.rv_valid && nxt.rv_trap.debug) n_step++;
      if (nxt.rv_valid && nxt.rv_trap.debug && nxt.rv_trap.exception) n_step_exc++;
      mdl = nxt;
    end
  end

  // The stimulus reacts at the next rising edge to the acks seen mid cycle
  always @(negedge clk_i) begin
    irq_ack_seen <= irq_ack_o;
    dbg_ack_seen <= dbg_ack_o;
  end

  always @(posedge clk_i) begin
    if (rst_ni) cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles without reaching the end of the test", cycle_cnt);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Drives a random instruction stream and drops irq and halt episodes on their ack
  task automatic drive_random_cycle(input int cyc);
    logic        valid;
    logic        in_step;
    int unsigned exc_rate;
    in_step  = (cyc >= STEP_FIRST) && (cyc < STEP_LAST);
    exc_rate = in_step ? 3 : 40;
    valid    = ($random(seed) & 3) != 0;
    instr_valid_i     <= valid;
    instr_pc_i        <= pc_next;
    instr_exc_i       <= ($unsigned($random(seed)) % exc_rate) == 0;
    instr_exc_cause_i <= `TRAP_TRACE_CAUSE_W'($random(seed));
    instr_dret_i      <= ($random(seed) & 7) == 0;
    step_i            <= in_step;
    if (valid) pc_next = pc_next + 32'd4;
    if (irq_i && irq_ack_seen) begin
      irq_i <= 1'b0;
    end else if (!irq_i && (($random(seed) & 63) == 0)) begin
      irq_i    <= 1'b1;
      irq_id_i <= `TRAP_TRACE_IRQ_ID_W'($random(seed));
    end
    if (dbg_req_i && dbg_ack_seen) begin
      dbg_req_i <= 1'b0;
    end else if (!dbg_req_i && (($unsigned($random(seed)) % 150) == 0)) begin
      dbg_req_i <= 1'b1;
    end
  endtask

  initial begin
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_pc_i        = '0;
    instr_exc_i       = 1'b0;
    instr_exc_cause_i = '0;
    instr_dret_i      = 1'b0;
    irq_i             = 1'b0;
    irq_id_i          = '0;
    dbg_req_i         = 1'b0;
    step_i            = 1'b0;
    pc_next           = 32'h0000_1000;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < STIM_CYCLES; i++) begin
      @(posedge clk_i);
      drive_random_cycle(i);
    end
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    irq_i         <= 1'b0;
    dbg_req_i     <= 1'b0;
    step_i        <= 1'b0;
    // The pipe is three deep, so four more edges drain the last retirement
    repeat (4) @(posedge clk_i);
    assert (n_irq_ack > 0 && n_dbg_ack > 0 && n_exc > 0 && n_step > 0 && n_step_exc > 0)
    else begin
      $display("Stimulus missed a case: irq %0d, halt %0d, exc %0d, step %0d, step+exc %0d",
               n_irq_ack, n_dbg_ack, n_exc, n_step, n_step_exc);
      other_cnt++;
    end
    other_cnt += u_trap_trace_top.u_props.fail_cnt;
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", check_cnt, err_cnt, other_cnt);
    if (err_cnt == 0 && other_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* trap_trace_top.f */
+incdir+include
src/trap_trace_pkg.sv
src/trace_stage_if.sv
src/trace_ctrl_fsm.sv
src/trace_pipe.sv
src/retire_counter.sv
src/trace_retire.sv
src/trap_trace_top.sv
test/trap_trace_props.sv
test/trap_trace_tb.sv

/* Makefile */
SIM  := obj_dir/Vtrap_trace_tb
SRCS := trap_trace_top.f $(wildcard include/*.svh src/*.sv test/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module trap_trace_tb -Mdir obj_dir -f trap_trace_top.f

# The run passes only if the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
